/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top_id -f src.f -o sim_top_id

status=0
./obj_dir/sim_top_id > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished cleanly"

/* source/branch_address_calculator.sv */
`timescale 1ns/1ps

module branch_address_calculator #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 11
) (
    input  id_pkg::branch_kind_e      i_branch_kind,
    input  logic [ADDR_W-1:0]         i_pc_next,

    input  logic [DATA_W-1:0]         i_data_a,
    input  logic [DATA_W-1:0]         i_data_b,
    input  logic [DATA_W-1:0]         i_imm_ext,
    input  logic [id_pkg::JIDX_W-1:0] i_jump_index,

    output logic                      o_branch_taken,
    output logic [ADDR_W-1:0]         o_branch_target
);

    logic              operands_equal;
    logic [ADDR_W-1:0] relative_target;

    assign operands_equal = (i_data_a == i_data_b);

    // Word offset, wraps inside the instruction memory.
    assign relative_target = i_pc_next + i_imm_ext[ADDR_W-1:0];

    //////////////////////////////////////////////////
    // Target select
    //////////////////////////////////////////////////

    always_comb begin
        case (i_branch_kind)
            id_pkg::BR_EQ: begin
                o_branch_taken  = operands_equal;
                o_branch_target = relative_target;
            end
            id_pkg::BR_NE: begin
                o_branch_taken  = !operands_equal;
                o_branch_target = relative_target;
            end
            id_pkg::BR_JUMP: begin
                o_branch_taken  = 1'b1;
                o_branch_target = i_jump_index[ADDR_W-1:0];
            end
            id_pkg::BR_JUMP_REG: begin
                o_branch_taken  = 1'b1;
                o_branch_target = i_data_a[ADDR_W-1:0];
            end
            default: begin
                o_branch_taken  = 1'b0;
                o_branch_target = '0;
            end
        endcase
    end

endmodule

/* source/id_pkg.sv */
package id_pkg;

    // ISA field widths.
    localparam int INSTR_W       = 32;
    localparam int OPCODE_W      = 6;
    localparam int FUNCT_W       = 6;
    localparam int SHAMT_W       = 5;
    localparam int IMM_W         = 16;
    localparam int JIDX_W        = 26;

    // Control field widths.
    localparam int ALU_OP_W      = 2;
    localparam int ALU_CTRL_W    = 4;
    localparam int BRANCH_KIND_W = 3;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'd0,  OP_J    = 6'd2,  OP_JAL  = 6'd3,  OP_BEQ  = 6'd4,
        OP_BNE   = 6'd5,  OP_ADDI = 6'd8,  OP_SLTI = 6'd10, OP_ANDI = 6'd12,
        OP_ORI   = 6'd13, OP_XORI = 6'd14, OP_LUI  = 6'd15, OP_LW   = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'd0,  FN_SRL  = 6'd2,  FN_SRA = 6'd3,  FN_JR  = 6'd8,
        FN_JALR = 6'd9,  FN_ADDU = 6'd33, FN_SUBU = 6'd35, FN_AND = 6'd36,
        FN_OR   = 6'd37, FN_XOR  = 6'd38, FN_NOR = 6'd39, FN_SLT = 6'd42
    } funct_e;

    // Operation class handed to the ALU control of execute.
    typedef enum logic [ALU_OP_W-1:0] {
        ALUOP_ADD   = 2'd0,
        ALUOP_SUB   = 2'd1,
        ALUOP_FUNCT = 2'd2,
        ALUOP_IMM   = 2'd3
    } alu_op_e;

    typedef enum logic [ALU_CTRL_W-1:0] {
        AC_ADD = 4'd0, AC_SUB = 4'd1, AC_AND = 4'd2, AC_OR  = 4'd3,
        AC_XOR = 4'd4, AC_NOR = 4'd5, AC_SLT = 4'd6, AC_SLL = 4'd7,
        AC_SRL = 4'd8, AC_SRA = 4'd9, AC_LUI = 4'd10
    } alu_ctrl_e;

    typedef enum logic [BRANCH_KIND_W-1:0] {
        BR_NONE     = 3'd0,
        BR_EQ       = 3'd1,
        BR_NE       = 3'd2,
        BR_JUMP     = 3'd3,
        BR_JUMP_REG = 3'd4
    } branch_kind_e;

endpackage

/* source/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 32
) (
    input  logic [id_pkg::INSTR_W-1:0]  i_instruction,

    output logic [$clog2(NUM_REGS)-1:0] o_reg_rs,
    output logic [$clog2(NUM_REGS)-1:0] o_reg_rt,
    output logic [$clog2(NUM_REGS)-1:0] o_reg_dst,
    output logic [DATA_W-1:0]           o_imm_ext,
    output logic [id_pkg::JIDX_W-1:0]   o_jump_index,
    output id_pkg::branch_kind_e        o_branch_kind,

    output logic                        o_reg_write,
    output logic                        o_alu_src,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output logic                        o_mem_to_reg,
    output logic                        o_link,
    output id_pkg::alu_op_e             o_alu_op,
    output id_pkg::alu_ctrl_e           o_alu_ctrl,
    output logic                        o_illegal
);

    localparam int REG_W = $clog2(NUM_REGS);

    // Register fields sit between opcode and immediate, 5 bits each.
    localparam int RF_W   = (id_pkg::INSTR_W - id_pkg::OPCODE_W - id_pkg::IMM_W) / 2;
    localparam int RT_LSB = id_pkg::IMM_W;
    localparam int RS_LSB = id_pkg::IMM_W + RF_W;
    localparam int RD_LSB = id_pkg::FUNCT_W + id_pkg::SHAMT_W;

    localparam logic [REG_W-1:0] LINK_REG = REG_W'(NUM_REGS - 1);

    id_pkg::opcode_e          opcode;
    id_pkg::funct_e           funct;
    logic [RF_W-1:0]          rs_field;
    logic [RF_W-1:0]          rt_field;
    logic [RF_W-1:0]          rd_field;
    logic [id_pkg::IMM_W-1:0] imm;
    logic                     zero_ext;

    logic                     r_valid;
    id_pkg::alu_ctrl_e        r_ctrl;
    id_pkg::alu_ctrl_e        imm_ctrl;

    //////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////

    assign opcode   = id_pkg::opcode_e'(i_instruction[id_pkg::INSTR_W-1 -: id_pkg::OPCODE_W]);
    assign funct    = id_pkg::funct_e'(i_instruction[id_pkg::FUNCT_W-1:0]);
    assign rs_field = i_instruction[RS_LSB +: RF_W];
    assign rt_field = i_instruction[RT_LSB +: RF_W];
    assign rd_field = i_instruction[RD_LSB +: RF_W];
    assign imm      = i_instruction[id_pkg::IMM_W-1:0];

    assign o_reg_rs     = rs_field[REG_W-1:0];
    assign o_reg_rt     = rt_field[REG_W-1:0];
    assign o_jump_index = i_instruction[id_pkg::JIDX_W-1:0];

    // Logical immediates and LUI take the raw field.
    assign zero_ext = (opcode == id_pkg::OP_ANDI) || (opcode == id_pkg::OP_ORI) ||
                      (opcode == id_pkg::OP_XORI) || (opcode == id_pkg::OP_LUI);

    assign o_imm_ext = zero_ext ? {{(DATA_W - id_pkg::IMM_W){1'b0}}, imm}
                                : {{(DATA_W - id_pkg::IMM_W){imm[id_pkg::IMM_W-1]}}, imm};

    //////////////////////////////////////////////////
    // ALU control lookup
    //////////////////////////////////////////////////

    always_comb begin
        r_valid = 1'b1;
        r_ctrl  = id_pkg::AC_ADD;
        case (funct)
            id_pkg::FN_SLL:  r_ctrl = id_pkg::AC_SLL;
            id_pkg::FN_SRL:  r_ctrl = id_pkg::AC_SRL;
            id_pkg::FN_SRA:  r_ctrl = id_pkg::AC_SRA;
            id_pkg::FN_ADDU: r_ctrl = id_pkg::AC_ADD;
            id_pkg::FN_SUBU: r_ctrl = id_pkg::AC_SUB;
            id_pkg::FN_AND:  r_ctrl = id_pkg::AC_AND;
            id_pkg::FN_OR:   r_ctrl = id_pkg::AC_OR;
            id_pkg::FN_XOR:  r_ctrl = id_pkg::AC_XOR;
            id_pkg::FN_NOR:  r_ctrl = id_pkg::AC_NOR;
            id_pkg::FN_SLT:  r_ctrl = id_pkg::AC_SLT;
            // Link address is formed by an add in execute.
            id_pkg::FN_JR, id_pkg::FN_JALR: r_ctrl = id_pkg::AC_ADD;
            default:         r_valid = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            id_pkg::OP_SLTI: imm_ctrl = id_pkg::AC_SLT;
            id_pkg::OP_ANDI: imm_ctrl = id_pkg::AC_AND;
            id_pkg::OP_ORI:  imm_ctrl = id_pkg::AC_OR;
            id_pkg::OP_XORI: imm_ctrl = id_pkg::AC_XOR;
            id_pkg::OP_LUI:  imm_ctrl = id_pkg::AC_LUI;
            default:         imm_ctrl = id_pkg::AC_ADD;
        endcase
    end

    //////////////////////////////////////////////////
    // Main control
    //////////////////////////////////////////////////

    always_comb begin
        o_reg_write   = 1'b0;
        o_alu_src     = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_mem_to_reg  = 1'b0;
        o_link        = 1'b0;
        o_alu_op      = id_pkg::ALUOP_ADD;
        o_alu_ctrl    = id_pkg::AC_ADD;
        o_branch_kind = id_pkg::BR_NONE;
        o_reg_dst     = rt_field[REG_W-1:0];
        o_illegal     = 1'b0;

        case (opcode)
            id_pkg::OP_RTYPE: begin
                if (r_valid) begin
                    o_alu_op    = id_pkg::ALUOP_FUNCT;
                    o_alu_ctrl  = r_ctrl;
                    o_reg_dst   = rd_field[REG_W-1:0];
                    o_reg_write = (funct != id_pkg::FN_JR);
                    o_link      = (funct == id_pkg::FN_JALR);
                    if (funct == id_pkg::FN_JR || funct == id_pkg::FN_JALR) begin
                        o_branch_kind = id_pkg::BR_JUMP_REG;
                    end
                end else begin
                    o_illegal = 1'b1;
                end
            end
            id_pkg::OP_J: begin
                o_branch_kind = id_pkg::BR_JUMP;
            end
            id_pkg::OP_JAL: begin
                o_branch_kind = id_pkg::BR_JUMP;
                o_link        = 1'b1;
                o_reg_write   = 1'b1;
                o_reg_dst     = LINK_REG;
            end
            id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
                o_alu_op      = id_pkg::ALUOP_SUB;
                o_alu_ctrl    = id_pkg::AC_SUB;
                o_branch_kind = (opcode == id_pkg::OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
            end
            id_pkg::OP_ADDI, id_pkg::OP_SLTI, id_pkg::OP_ANDI,
            id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = id_pkg::ALUOP_IMM;
                o_alu_ctrl  = imm_ctrl;
            end
            id_pkg::OP_LW: begin
                o_reg_write  = 1'b1;
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
            end
            id_pkg::OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 32
) (
    input  logic                        i_clock,
    input  logic                        i_arst_n,

    input  logic [$clog2(NUM_REGS)-1:0] i_reg_a,
    input  logic [$clog2(NUM_REGS)-1:0] i_reg_b,

    input  logic                        i_wb_write,
    input  logic [$clog2(NUM_REGS)-1:0] i_wb_reg,
    input  logic [DATA_W-1:0]           i_wb_data,

    output logic [DATA_W-1:0]           o_data_a,
    output logic [DATA_W-1:0]           o_data_b
);

    localparam int REG_W = $clog2(NUM_REGS);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Zero register, then write-through, then storage.
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_W-1:0] idx);
        logic [DATA_W-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (i_wb_write && (i_wb_reg == idx)) begin
            value = i_wb_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_write && (i_wb_reg != '0)) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    // Read ports.
    always_comb begin
        o_data_a = read_port(i_reg_a);
        o_data_b = read_port(i_reg_b);
    end

endmodule

/* source/top_id.sv */
`timescale 1ns/1ps

module top_id #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 32,
    parameter int ADDR_W   = 11
) (
    input  logic                        i_clock,
    input  logic                        i_arst_n,

    // From fetch.
    input  logic [id_pkg::INSTR_W-1:0]  i_instruction,
    input  logic [ADDR_W-1:0]           i_pc_next,

    // From write-back.
    input  logic                        i_wb_write,
    input  logic [$clog2(NUM_REGS)-1:0] i_wb_reg,
    input  logic [DATA_W-1:0]           i_wb_data,

    output logic                        o_branch_taken,
    output logic [ADDR_W-1:0]           o_branch_target,

    output logic [DATA_W-1:0]           o_data_a,
    output logic [DATA_W-1:0]           o_data_b,
    output logic [DATA_W-1:0]           o_imm_ext,

    output logic [$clog2(NUM_REGS)-1:0] o_reg_rs,
    output logic [$clog2(NUM_REGS)-1:0] o_reg_rt,
    output logic [$clog2(NUM_REGS)-1:0] o_reg_dst,

    // Control levels for execute, memory and write-back.
    output logic                        o_reg_write,
    output logic                        o_alu_src,
    output id_pkg::alu_op_e             o_alu_op,
    output id_pkg::alu_ctrl_e           o_alu_ctrl,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output logic                        o_mem_to_reg,
    output logic                        o_link,
    output logic                        o_illegal
);

    id_pkg::branch_kind_e        branch_kind;
    logic [id_pkg::JIDX_W-1:0]   jump_index;

    //////////////////////////////////////////////////
    // Decode, operand read, branch resolve
    //////////////////////////////////////////////////

    instruction_decoder #(
        .DATA_W   (DATA_W),
        .NUM_REGS (NUM_REGS)
    ) u_instruction_decoder (
        .i_instruction (i_instruction),
        .o_reg_rs      (o_reg_rs),
        .o_reg_rt      (o_reg_rt),
        .o_reg_dst     (o_reg_dst),
        .o_imm_ext     (o_imm_ext),
        .o_jump_index  (jump_index),
        .o_branch_kind (branch_kind),
        .o_reg_write   (o_reg_write),
        .o_alu_src     (o_alu_src),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_link        (o_link),
        .o_alu_op      (o_alu_op),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_illegal     (o_illegal)
    );

    register_file #(
        .DATA_W   (DATA_W),
        .NUM_REGS (NUM_REGS)
    ) u_register_file (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_reg_a    (o_reg_rs),
        .i_reg_b    (o_reg_rt),
        .i_wb_write (i_wb_write),
        .i_wb_reg   (i_wb_reg),
        .i_wb_data  (i_wb_data),
        .o_data_a   (o_data_a),
        .o_data_b   (o_data_b)
    );

    branch_address_calculator #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_branch_address_calculator (
        .i_branch_kind   (branch_kind),
        .i_pc_next       (i_pc_next),
        .i_data_a        (o_data_a),
        .i_data_b        (o_data_b),
        .i_imm_ext       (o_imm_ext),
        .i_jump_index    (jump_index),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

endmodule

/* src.f */
source/id_pkg.sv
source/instruction_decoder.sv
source/register_file.sv
source/branch_address_calculator.sv
source/top_id.sv
tests/tb_clock_gen.sv
tests/top_id_props.sv
tests/tb_top_id.sv

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

endmodule

/* tests/tb_top_id.sv */
`timescale 1ns/1ps

module tb_top_id;

    localparam int DATA_W     = 32;
    localparam int NUM_REGS   = 32;
    localparam int ADDR_W     = 11;
    localparam int REG_W      = $clog2(NUM_REGS);
    localparam int PERIOD_NS  = 100;
    localparam int SETTLE_NS  = 10;
    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT_NS = NUM_TESTS * 200 * PERIOD_NS;

    logic                     i_clock;
    logic                     i_arst_n;
    logic [31:0]              i_instruction;
    logic [ADDR_W-1:0]        i_pc_next;
    logic                     i_wb_write;
    logic [REG_W-1:0]         i_wb_reg;
    logic [DATA_W-1:0]        i_wb_data;
    logic                     o_branch_taken;
    logic [ADDR_W-1:0]        o_branch_target;
    logic [DATA_W-1:0]        o_data_a;
    logic [DATA_W-1:0]        o_data_b;
    logic [DATA_W-1:0]        o_imm_ext;
    logic [REG_W-1:0]         o_reg_rs;
    logic [REG_W-1:0]         o_reg_rt;
    logic [REG_W-1:0]         o_reg_dst;
    logic                     o_reg_write;
    logic                     o_alu_src;
    id_pkg::alu_op_e          o_alu_op;
    id_pkg::alu_ctrl_e        o_alu_ctrl;
    logic                     o_mem_read;
    logic                     o_mem_write;
    logic                     o_mem_to_reg;
    logic                     o_link;
    logic                     o_illegal;

    // Expected register contents.
    logic [DATA_W-1:0]        shadow [NUM_REGS];
    int                       error_count;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) clk0 (.o_clock(i_clock));

    top_id dut0 (.*);

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("** Error [%s] %s: expected %0h, actual %0h", test, what, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // Encoders and drivers
    //////////////////////////////////////////////////

    function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [5:0] fn);
        return {6'd0, rs, rt, rd, 5'($urandom()), fn};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_jump(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic apply_instruction(input logic [31:0] instr, input logic [ADDR_W-1:0] pc);
        @(negedge i_clock);
        i_instruction = instr;
        i_pc_next     = pc;
        #(SETTLE_NS);
    endtask

    task automatic check_registers(input string test, input logic [4:0] ra,
                                   input logic [4:0] rb);
        apply_instruction(encode_rtype(ra, rb, 5'd0, id_pkg::FN_ADDU), '0);
        check_value(test, "rs index", 32'(ra), 32'(o_reg_rs));
        check_value(test, "rt index", 32'(rb), 32'(o_reg_rt));
        check_value(test, "port a", shadow[ra], o_data_a);
        check_value(test, "port b", shadow[rb], o_data_b);
    endtask

    task automatic write_register(input string test, input logic [4:0] idx,
                                  input logic [31:0] data);
        @(negedge i_clock);
        i_wb_write    = 1'b1;
        i_wb_reg      = idx;
        i_wb_data     = data;
        i_instruction = encode_rtype(idx, idx, 5'd0, id_pkg::FN_ADDU);
        #(SETTLE_NS);
        // Write-through during the write cycle except for register zero.
        check_value(test, "bypass a", (idx == '0) ? 32'd0 : data, o_data_a);
        check_value(test, "bypass b", (idx == '0) ? 32'd0 : data, o_data_b);
        @(posedge i_clock);
        if (idx != '0) begin
            shadow[idx] = data;
        end
        @(negedge i_clock);
        i_wb_write = 1'b0;
        #(SETTLE_NS);
        check_value(test, "stored a", shadow[idx], o_data_a);
        check_value(test, "stored b", shadow[idx], o_data_b);
    endtask

    task automatic check_inactive(input string test);
        check_value(test, "illegal", 32'd1, 32'(o_illegal));
        check_value(test, "reg write", 32'd0, 32'(o_reg_write));
        check_value(test, "mem read", 32'd0, 32'(o_mem_read));
        check_value(test, "mem write", 32'd0, 32'(o_mem_write));
        check_value(test, "mem to reg", 32'd0, 32'(o_mem_to_reg));
        check_value(test, "link", 32'd0, 32'(o_link));
        check_value(test, "taken", 32'd0, 32'(o_branch_taken));
        check_value(test, "target", 32'd0, 32'(o_branch_target));
    endtask

    task automatic check_branch(input logic [5:0] op, input logic [15:0] imm,
                                input logic [ADDR_W-1:0] pc, input logic taken);
        logic [ADDR_W-1:0] target;
        // Word offset wraps at the top of the address space.
        target = pc + imm[ADDR_W-1:0];
        apply_instruction(encode_itype(op, 5'd5, 5'd6, imm), pc);
        check_value("branch", "taken", 32'(taken), 32'(o_branch_taken));
        check_value("branch", "target", 32'(target), 32'(o_branch_target));
        check_value("branch", "reg write", 32'd0, 32'(o_reg_write));
        check_value("branch", "alu op", 32'(id_pkg::ALUOP_SUB), 32'(o_alu_op));
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic run_reset_test();
        for (int r = 0; r < NUM_REGS; r++) begin
            check_registers("reset", 5'(r), 5'(NUM_REGS - 1 - r));
        end
    endtask

    task automatic run_regfile_test();
        for (int n = 0; n < 24; n++) begin
            write_register("regfile", 5'($urandom_range(NUM_REGS - 1, 1)), $urandom());
        end
        write_register("regfile", 5'd0, $urandom() | 32'd1);
        for (int r = 0; r < NUM_REGS; r++) begin
            check_registers("regfile", 5'(r), 5'(r));
        end
    endtask

    task automatic run_rtype_test();
        logic [5:0] fn_list [12];
        logic [3:0] ctrl_list [12];
        logic [4:0] rd;
        fn_list   = '{id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA, id_pkg::FN_ADDU,
                      id_pkg::FN_SUBU, id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR,
                      id_pkg::FN_NOR, id_pkg::FN_SLT, id_pkg::FN_JR, id_pkg::FN_JALR};
        ctrl_list = '{id_pkg::AC_SLL, id_pkg::AC_SRL, id_pkg::AC_SRA, id_pkg::AC_ADD,
                      id_pkg::AC_SUB, id_pkg::AC_AND, id_pkg::AC_OR, id_pkg::AC_XOR,
                      id_pkg::AC_NOR, id_pkg::AC_SLT, id_pkg::AC_ADD, id_pkg::AC_ADD};
        for (int k = 0; k < 12; k++) begin
            rd = 5'($urandom());
            apply_instruction(encode_rtype(5'($urandom()), 5'($urandom()), rd, fn_list[k]), '0);
            check_value("rtype", "alu ctrl", 32'(ctrl_list[k]), 32'(o_alu_ctrl));
            check_value("rtype", "alu op", 32'(id_pkg::ALUOP_FUNCT), 32'(o_alu_op));
            check_value("rtype", "dst", 32'(rd), 32'(o_reg_dst));
            check_value("rtype", "reg write", 32'(fn_list[k] != id_pkg::FN_JR), 32'(o_reg_write));
            check_value("rtype", "link", 32'(fn_list[k] == id_pkg::FN_JALR), 32'(o_link));
            check_value("rtype", "alu src", 32'd0, 32'(o_alu_src));
            check_value("rtype", "illegal", 32'd0, 32'(o_illegal));
        end
    endtask

    task automatic run_itype_test();
        logic [5:0]  op_list [8];
        logic [3:0]  ctrl_list [8];
        logic [15:0] imm;
        logic [31:0] expected_imm;
        logic [4:0]  rt;
        logic        is_load;
        logic        is_store;
        int          j;
        op_list   = '{id_pkg::OP_ADDI, id_pkg::OP_SLTI, id_pkg::OP_ANDI, id_pkg::OP_ORI,
                      id_pkg::OP_XORI, id_pkg::OP_LUI, id_pkg::OP_LW, id_pkg::OP_SW};
        ctrl_list = '{id_pkg::AC_ADD, id_pkg::AC_SLT, id_pkg::AC_AND, id_pkg::AC_OR,
                      id_pkg::AC_XOR, id_pkg::AC_LUI, id_pkg::AC_ADD, id_pkg::AC_ADD};
        for (int k = 0; k < 16; k++) begin
            // Each opcode once with the immediate sign bit set, once clear.
            j        = k / 2;
            rt       = 5'($urandom());
            imm      = {~k[0], 15'($urandom())};
            is_load  = (op_list[j] == id_pkg::OP_LW);
            is_store = (op_list[j] == id_pkg::OP_SW);
            if (op_list[j] inside {id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI,
                                   id_pkg::OP_LUI}) begin
                expected_imm = {16'd0, imm};
            end else begin
                expected_imm = {{16{imm[15]}}, imm};
            end
            apply_instruction(encode_itype(op_list[j], 5'($urandom()), rt, imm), '0);
            check_value("itype", "imm ext", expected_imm, o_imm_ext);
            check_value("itype", "alu src", 32'd1, 32'(o_alu_src));
            check_value("itype", "alu ctrl", 32'(ctrl_list[j]), 32'(o_alu_ctrl));
            check_value("itype", "alu op", (is_load || is_store) ? 32'(id_pkg::ALUOP_ADD)
                        : 32'(id_pkg::ALUOP_IMM), 32'(o_alu_op));
            check_value("itype", "mem read", 32'(is_load), 32'(o_mem_read));
            check_value("itype", "mem write", 32'(is_store), 32'(o_mem_write));
            check_value("itype", "mem to reg", 32'(is_load), 32'(o_mem_to_reg));
            check_value("itype", "reg write", 32'(!is_store), 32'(o_reg_write));
            check_value("itype", "dst", 32'(rt), 32'(o_reg_dst));
        end
    endtask

    task automatic run_branch_test();
        logic [31:0] value;
        logic [5:0]  op;
        logic        equal;
        value = $urandom();
        write_register("branch", 5'd5, value);
        write_register("branch", 5'd6, value);
        for (int k = 0; k < 4; k++) begin
            if (k == 2) begin
                write_register("branch", 5'd6, ~value);
            end
            op    = (k % 2 == 0) ? id_pkg::OP_BEQ : id_pkg::OP_BNE;
            equal = (shadow[5] == shadow[6]);
            check_branch(op, 16'($urandom()), 11'($urandom()), (op == id_pkg::OP_BEQ) == equal);
        end
        // Offsets past either end of the address space.
        check_branch(id_pkg::OP_BNE, 16'h0020, 11'h7f0, !equal);
        check_branch(id_pkg::OP_BEQ, 16'hfff0, 11'h003, equal);
    endtask

    task automatic run_jump_test();
        logic [25:0] index;
        logic [31:0] value;
        logic [4:0]  rd;
        index = 26'($urandom());
        apply_instruction(encode_jump(id_pkg::OP_J, index), '0);
        check_value("jump", "j taken", 32'd1, 32'(o_branch_taken));
        check_value("jump", "j target", 32'(index[ADDR_W-1:0]), 32'(o_branch_target));
        check_value("jump", "j write", 32'd0, 32'(o_reg_write));
        index = 26'($urandom());
        apply_instruction(encode_jump(id_pkg::OP_JAL, index), '0);
        check_value("jump", "jal taken", 32'd1, 32'(o_branch_taken));
        check_value("jump", "jal target", 32'(index[ADDR_W-1:0]), 32'(o_branch_target));
        check_value("jump", "jal link", 32'd1, 32'(o_link));
        check_value("jump", "jal write", 32'd1, 32'(o_reg_write));
        check_value("jump", "jal dst", NUM_REGS - 1, 32'(o_reg_dst));
        value = $urandom();
        rd    = 5'($urandom_range(NUM_REGS - 1, 1));
        write_register("jump", 5'd7, value);
        apply_instruction(encode_rtype(5'd7, 5'd0, rd, id_pkg::FN_JR), '0);
        check_value("jump", "jr taken", 32'd1, 32'(o_branch_taken));
        check_value("jump", "jr target", 32'(value[ADDR_W-1:0]), 32'(o_branch_target));
        check_value("jump", "jr write", 32'd0, 32'(o_reg_write));
        apply_instruction(encode_rtype(5'd7, 5'd0, rd, id_pkg::FN_JALR), '0);
        check_value("jump", "jalr target", 32'(value[ADDR_W-1:0]), 32'(o_branch_target));
        check_value("jump", "jalr link", 32'd1, 32'(o_link));
        check_value("jump", "jalr dst", 32'(rd), 32'(o_reg_dst));
        // Unused opcode, then an unused function code.
        apply_instruction(encode_itype(6'd1, 5'd7, 5'd7, 16'($urandom())), '0);
        check_inactive("illegal opcode");
        apply_instruction(encode_rtype(5'd7, 5'd7, rd, 6'd1), '0);
        check_inactive("illegal funct");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h2f46));
        error_count   = 0;
        i_arst_n      = 1'b0;
        i_instruction = '0;
        i_pc_next     = '0;
        i_wb_write    = 1'b0;
        i_wb_reg      = '0;
        i_wb_data     = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(negedge i_clock);
        i_arst_n = 1'b1;

        run_reset_test();
        run_regfile_test();
        run_rtype_test();
        run_itype_test();
        run_branch_test();
        run_jump_test();

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/top_id_props.sv */
`timescale 1ns/1ps

module top_id_props #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 32
) (
    input logic                        i_clock,
    input logic                        i_arst_n,
    input logic [$clog2(NUM_REGS)-1:0] i_reg_rs,
    input logic [$clog2(NUM_REGS)-1:0] i_reg_rt,
    input logic [DATA_W-1:0]           i_data_a,
    input logic [DATA_W-1:0]           i_data_b,
    input logic                        i_branch_taken,
    input id_pkg::branch_kind_e        i_branch_kind,
    input logic                        i_mem_read,
    input logic                        i_mem_write
);

    // Register zero on either port.
    zero_reg_reads_zero: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_reg_rs != '0 || i_data_a == '0) && (i_reg_rt != '0 || i_data_b == '0))
        else $error("register zero returned nonzero data");

    taken_needs_branch: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_branch_taken |-> (i_branch_kind != id_pkg::BR_NONE))
        else $error("branch taken without a branch kind");

    mem_read_write_exclusive: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !(i_mem_read && i_mem_write))
        else $error("memory read and write requested together");

endmodule

bind top_id top_id_props #(
    .DATA_W   (DATA_W),
    .NUM_REGS (NUM_REGS)
) props0 (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_reg_rs       (o_reg_rs),
    .i_reg_rt       (o_reg_rt),
    .i_data_a       (o_data_a),
    .i_data_b       (o_data_b),
    .i_branch_taken (o_branch_taken),
    .i_branch_kind  (branch_kind),
    .i_mem_read     (o_mem_read),
    .i_mem_write    (o_mem_write)
);
